// File: filelist.f
+incdir+source
source/bp_pkg.sv
source/bp_state_control.sv
source/bp_shifter.sv
source/bp_mapper.sv
source/bp_line_buffer.sv
source/bp_top.sv
tb/bp_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the back-projection testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module bp_tb -o bp_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/bp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: source/bp_defs.svh
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// projection line geometry
`define BP_LINE_SIZE        256
`define BP_S_WIDTH          8
`define BP_SAMPLE_WIDTH     12
`define BP_SUM_WIDTH        24

// fixed-point position, low bits are fraction
`define BP_ACCU_WIDTH       18
`define BP_ACCU_FRAC        8

// 0 to 256 steps per run
`define BP_STEP_WIDTH       9

// APB port
`define BP_APB_ADDR_WIDTH   12
`define BP_APB_DATA_WIDTH   32

// register map, samples sit below BP_REG_START
`define BP_REG_START        12'h400
`define BP_REG_STEP         12'h404
`define BP_REG_COUNT        12'h408
`define BP_REG_CTRL         12'h40C
`define BP_REG_STATUS       12'h410
`define BP_REG_SUM          12'h414

`endif

// File: source/bp_line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_defs.svh"

module bp_line_buffer
    import bp_pkg::*;
(
    input  wire          clk,
    input  wire          reset_n,
    input  wire          buf_wr_en,
    input  wire s_val_t  buf_wr_addr,
    input  wire sample_t buf_wr_data,
    input  wire s_val_t  rm_s_val,
    input  wire          rm_en,
    input  wire          sum_clear,
    output ray_sum_t     ray_sum
);

    sample_t ram [`BP_LINE_SIZE];
    sample_t rd_data;
    logic    rd_valid;

    // host load port
    always_ff @(posedge clk)
    begin
        if (buf_wr_en)
            ram[buf_wr_addr] <= buf_wr_data;
    end

    // registered read
    always_ff @(posedge clk)
    begin
        if (rm_en)
            rd_data <= ram[rm_s_val];
    end

    // valid follows the read data one stage behind the request
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rd_valid <= 1'b0;
        else
            rd_valid <= rm_en;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            ray_sum <= '0;
        else if (sum_clear)
            ray_sum <= '0;
        else if (rd_valid)
            ray_sum <= ray_sum + ray_sum_t'(rd_data);
    end

endmodule

`default_nettype wire

// File: source/bp_mapper.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_defs.svh"

module bp_mapper
    import bp_pkg::*;
(
    input  wire            clk,
    input  wire            reset_n,
    input  wire map_accu_t mp_accu_init,
    input  wire map_accu_t mp_accu_base,
    input  wire            sh_kick,
    input  wire            sh_shift_en,
    input  wire            sh_done,
    output s_val_t         rm_s_val,
    output logic           rm_en
);

    mapper_state_t state;
    mapper_state_t next_state;
    map_accu_t     accu;
    logic          mapping;
    logic          in_range;

    assign mapping = (state == map_mapping);

    // integer part in 0 .. BP_LINE_SIZE-1
    assign in_range = !accu[`BP_ACCU_WIDTH-1] &&
                      (accu[`BP_ACCU_WIDTH-1:`BP_ACCU_FRAC] < `BP_LINE_SIZE);

    // floor of the position, zero outside the line
    always_comb
    begin
        if (mapping && in_range)
            rm_s_val = accu[`BP_ACCU_FRAC +: `BP_S_WIDTH];
        else
            rm_s_val = '0;
    end

    // out-of-line positions skip the read entirely
    assign rm_en = sh_shift_en && mapping && in_range;

    always_ff @(posedge clk)
    begin
        if (!mapping)
            accu <= mp_accu_init;
        else if (sh_shift_en)
            accu <= accu + mp_accu_base;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= map_ready;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            map_ready:
                if (sh_kick)
                    next_state = map_mapping;
            map_mapping:
                if (sh_done)
                    next_state = map_ready;
            default:
                next_state = map_ready;
        endcase
    end

    // shifter frames every shift inside the mapping window
    a_shift_in_mapping: assert property (@(posedge clk) disable iff (!reset_n)
        sh_shift_en |-> mapping);

endmodule

`default_nettype wire

// File: source/bp_pkg.sv
`default_nettype none

`include "bp_defs.svh"

package bp_pkg;

    // line buffer address
    typedef logic [`BP_S_WIDTH-1:0] s_val_t;

    typedef logic signed [`BP_SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [`BP_SUM_WIDTH-1:0] ray_sum_t;

    // signed position, BP_ACCU_FRAC fraction bits
    typedef logic signed [`BP_ACCU_WIDTH-1:0] map_accu_t;

    typedef logic [`BP_STEP_WIDTH-1:0] step_count_t;

    typedef enum logic {map_ready, map_mapping} mapper_state_t;
    typedef enum logic {shift_idle, shift_run} shifter_state_t;
    typedef enum logic [1:0] {ctl_idle, ctl_run, ctl_drain} control_state_t;

endpackage

`default_nettype wire

// File: source/bp_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module bp_shifter
    import bp_pkg::*;
(
    input  wire              clk,
    input  wire              reset_n,
    input  wire              run_start,
    input  wire step_count_t step_count,
    output logic             sh_kick,
    output logic             sh_shift_en,
    output logic             sh_done
);

    shifter_state_t state;
    step_count_t    remain;

    // kick, then one shift per remaining step, then done
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state       <= shift_idle;
            remain      <= '0;
            sh_kick     <= 1'b0;
            sh_shift_en <= 1'b0;
            sh_done     <= 1'b0;
        end
        else
        begin
            sh_kick <= 1'b0;
            sh_done <= 1'b0;
            case (state)
                shift_idle:
                begin
                    sh_shift_en <= 1'b0;
                    if (run_start)
                    begin
                        remain  <= step_count;
                        sh_kick <= 1'b1;
                        state   <= shift_run;
                    end
                end
                shift_run:
                    if (remain != '0)
                    begin
                        sh_shift_en <= 1'b1;
                        remain      <= remain - 1'b1;
                    end
                    else
                    begin
                        // last shift was the previous cycle
                        sh_shift_en <= 1'b0;
                        sh_done     <= 1'b1;
                        state       <= shift_idle;
                    end
                default:
                    state <= shift_idle;
            endcase
        end
    end

    a_shift_only_running: assert property (@(posedge clk) disable iff (!reset_n)
        sh_shift_en |-> state == shift_run);

endmodule

`default_nettype wire

// File: source/bp_state_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_defs.svh"

module bp_state_control
    import bp_pkg::*;
(
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire [`BP_APB_ADDR_WIDTH-1:0]  paddr,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire [`BP_APB_DATA_WIDTH-1:0]  pwdata,
    output logic [`BP_APB_DATA_WIDTH-1:0] prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  wire                           sh_done,
    input  wire ray_sum_t                 ray_sum,
    output logic                          run_start,
    output logic                          sum_clear,
    output logic                          buf_wr_en,
    output s_val_t                        buf_wr_addr,
    output sample_t                       buf_wr_data,
    output map_accu_t                     mp_accu_init,
    output map_accu_t                     mp_accu_base,
    output step_count_t                   step_count
);

    control_state_t state;
    logic           drain_cnt;
    logic           busy;
    logic           apb_access;
    logic           apb_write;
    logic           start_req;

    assign apb_access = psel && penable;
    assign apb_write  = apb_access && pwrite;
    assign busy       = (state != ctl_idle);
    assign start_req  = apb_write && (paddr == `BP_REG_CTRL) && pwdata[0];

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = apb_access && (paddr > `BP_REG_SUM);

    // sample words go straight to the line RAM
    assign buf_wr_en   = apb_write && (paddr < `BP_REG_START);
    assign buf_wr_addr = paddr[`BP_S_WIDTH+1:2];
    assign buf_wr_data = pwdata[`BP_SAMPLE_WIDTH-1:0];

    // run parameters, frozen while busy
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mp_accu_init <= '0;
            mp_accu_base <= '0;
            step_count   <= '0;
        end
        else if (apb_write && !busy)
        begin
            case (paddr)
                `BP_REG_START: mp_accu_init <= pwdata[`BP_ACCU_WIDTH-1:0];
                `BP_REG_STEP:  mp_accu_base <= pwdata[`BP_ACCU_WIDTH-1:0];
                `BP_REG_COUNT: step_count   <= pwdata[`BP_STEP_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // idle, run until the shifter is done, then let the last sample land
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state     <= ctl_idle;
            drain_cnt <= 1'b0;
            run_start <= 1'b0;
            sum_clear <= 1'b0;
        end
        else
        begin
            run_start <= 1'b0;
            sum_clear <= 1'b0;
            case (state)
                ctl_idle:
                    if (start_req)
                    begin
                        run_start <= 1'b1;
                        sum_clear <= 1'b1;
                        state     <= ctl_run;
                    end
                ctl_run:
                    if (sh_done)
                    begin
                        drain_cnt <= 1'b0;
                        state     <= ctl_drain;
                    end
                ctl_drain:
                    if (drain_cnt)
                        state <= ctl_idle;
                    else
                        drain_cnt <= 1'b1;
                default:
                    state <= ctl_idle;
            endcase
        end
    end

    always_comb
    begin
        prdata = '0;
        case (paddr)
            `BP_REG_START:
                prdata = {{(`BP_APB_DATA_WIDTH-`BP_ACCU_WIDTH){mp_accu_init[`BP_ACCU_WIDTH-1]}},
                          mp_accu_init};
            `BP_REG_STEP:
                prdata = {{(`BP_APB_DATA_WIDTH-`BP_ACCU_WIDTH){mp_accu_base[`BP_ACCU_WIDTH-1]}},
                          mp_accu_base};
            `BP_REG_COUNT:
                prdata = {{(`BP_APB_DATA_WIDTH-`BP_STEP_WIDTH){1'b0}}, step_count};
            `BP_REG_STATUS:
                prdata = {{(`BP_APB_DATA_WIDTH-1){1'b0}}, busy};
            `BP_REG_SUM:
                prdata = {{(`BP_APB_DATA_WIDTH-`BP_SUM_WIDTH){ray_sum[`BP_SUM_WIDTH-1]}}, ray_sum};
            default: ;
        endcase
    end

    // error only in an access phase that followed its setup phase
    a_err_in_access: assert property (@(posedge clk) disable iff (!reset_n)
        pslverr |-> penable && $past(psel) && !$past(penable));

    // a new run never starts on top of one in progress
    a_no_restart: assert property (@(posedge clk) disable iff (!reset_n)
        run_start |-> !$past(busy));

endmodule

`default_nettype wire

// File: source/bp_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_defs.svh"

module bp_top
    import bp_pkg::*;
(
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire [`BP_APB_ADDR_WIDTH-1:0] paddr,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire [`BP_APB_DATA_WIDTH-1:0] pwdata,
    output wire [`BP_APB_DATA_WIDTH-1:0] prdata,
    output wire                          pready,
    output wire                          pslverr
);

    logic        run_start;
    logic        sum_clear;
    logic        sh_kick;
    logic        sh_shift_en;
    logic        sh_done;
    logic        rm_en;
    s_val_t      rm_s_val;
    logic        buf_wr_en;
    s_val_t      buf_wr_addr;
    sample_t     buf_wr_data;
    ray_sum_t    ray_sum;
    map_accu_t   mp_accu_init;
    map_accu_t   mp_accu_base;
    step_count_t step_count;

    bp_state_control u_state_control (
        .clk          (clk),
        .reset_n      (reset_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .sh_done      (sh_done),
        .ray_sum      (ray_sum),
        .run_start    (run_start),
        .sum_clear    (sum_clear),
        .buf_wr_en    (buf_wr_en),
        .buf_wr_addr  (buf_wr_addr),
        .buf_wr_data  (buf_wr_data),
        .mp_accu_init (mp_accu_init),
        .mp_accu_base (mp_accu_base),
        .step_count   (step_count)
    );

    bp_shifter u_shifter (
        .clk         (clk),
        .reset_n     (reset_n),
        .run_start   (run_start),
        .step_count  (step_count),
        .sh_kick     (sh_kick),
        .sh_shift_en (sh_shift_en),
        .sh_done     (sh_done)
    );

    bp_mapper u_mapper (
        .clk          (clk),
        .reset_n      (reset_n),
        .mp_accu_init (mp_accu_init),
        .mp_accu_base (mp_accu_base),
        .sh_kick      (sh_kick),
        .sh_shift_en  (sh_shift_en),
        .sh_done      (sh_done),
        .rm_s_val     (rm_s_val),
        .rm_en        (rm_en)
    );

    bp_line_buffer u_line_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data),
        .rm_s_val    (rm_s_val),
        .rm_en       (rm_en),
        .sum_clear   (sum_clear),
        .ray_sum     (ray_sum)
    );

endmodule

`default_nettype wire

// File: tb/bp_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_defs.svh"

module bp_tb;

    localparam int     CLK_HALF_NS = 4;
    localparam int     MAX_RUNS    = 40;
    localparam int     RUN_CYCLES  = 600;
    localparam longint WATCHDOG_NS = MAX_RUNS * RUN_CYCLES * 2 * CLK_HALF_NS;
    localparam int     POLL_LIMIT  = 400;
    // keeps every used position clear of the 18-bit wrap
    localparam int     POS_LIMIT   = 120000;

    logic                          clk;
    logic                          reset_n;
    logic [`BP_APB_ADDR_WIDTH-1:0] paddr;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [`BP_APB_DATA_WIDTH-1:0] pwdata;
    wire  [`BP_APB_DATA_WIDTH-1:0] prdata;
    wire                           pready;
    wire                           pslverr;

    // reference copy of the projection line
    int          line [`BP_LINE_SIZE];
    int          total;
    int          p;
    int          b;
    int          n;
    logic [31:0] rd;
    logic        err;

    bp_top dut (
        .clk     (clk),
        .reset_n (reset_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #CLK_HALF_NS clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string what, input longint got, input longint exp);
        assert (got == exp)
        else fail_now($sformatf("[FAIL] %0d ns: %s, got %0d, expected %0d",
                                $time, what, got, exp));
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic slv_err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        assert (pready)
        else fail_now("pready was low during an APB access phase");
        data    = prdata;
        slv_err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_idle();
        int          polls;
        logic [31:0] st;
        logic        st_err;
        polls = 0;
        st    = 32'd1;
        while (st[0])
        begin
            apb_read(`BP_REG_STATUS, st, st_err);
            polls++;
            assert (polls <= POLL_LIMIT)
            else fail_now("busy never cleared after a run was started");
        end
    endtask

    // floor of each position in 8-fraction-bit units, out-of-line samples skipped
    function automatic int expected_sum(input int pos0, input int step, input int count);
        int sum;
        int pos;
        int idx;
        sum = 0;
        for (int k = 0; k < count; k++)
        begin
            pos = pos0 + k * step;
            idx = pos >>> `BP_ACCU_FRAC;
            if (idx >= 0 && idx < `BP_LINE_SIZE)
                sum += line[idx];
        end
        return sum;
    endfunction

    function automatic int fit_count(input int pos0, input int step, input int count);
        int c;
        c = count;
        while (c > 0 && (pos0 + (c - 1) * step > POS_LIMIT || pos0 + (c - 1) * step < -POS_LIMIT))
            c--;
        return c;
    endfunction

    // one complete run, optionally poking the step register while busy
    task automatic do_run(input int pos0, input int step, input int count, input bit poke_step);
        logic [31:0] r;
        logic        e;
        apb_write(`BP_REG_START, 32'(pos0));
        apb_write(`BP_REG_STEP, 32'(step));
        apb_write(`BP_REG_COUNT, 32'(count));
        apb_write(`BP_REG_CTRL, 32'd1);
        apb_read(`BP_REG_STATUS, r, e);
        check_value("busy right after start", longint'(r[0]), 1);
        if (poke_step)
            apb_write(`BP_REG_STEP, 32'(step + 77));
        wait_idle();
        apb_read(`BP_REG_SUM, r, e);
        check_value($sformatf("ray sum p=%0d b=%0d n=%0d", pos0, step, count),
                    longint'($signed(r)), expected_sum(pos0, step, count));
        apb_read(`BP_REG_START, r, e);
        check_value("start position readback", longint'($signed(r)), pos0);
        apb_read(`BP_REG_STEP, r, e);
        check_value("step readback", longint'($signed(r)), step);
        apb_read(`BP_REG_COUNT, r, e);
        check_value("step count readback", longint'(r), count);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        fail_now("watchdog expired before the tests finished");
    end

    initial
    begin
        clk     = 1'b0;
        reset_n = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        void'($urandom(34865));
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        // load the line and walk it once at unit step
        total = 0;
        for (int i = 0; i < `BP_LINE_SIZE; i++)
        begin
            line[i] = int'($urandom_range(4095, 0)) - 2048;
            total += line[i];
            apb_write(12'(i * 4), 32'(line[i]));
        end
        do_run(0, 256, 256, 1'b0);
        apb_read(`BP_REG_SUM, rd, err);
        check_value("full line sum", longint'($signed(rd)), total);

        // fractional steps from in-range starts
        for (int r = 0; r < 30; r++)
        begin
            p = int'($urandom_range(`BP_LINE_SIZE * 256 - 1, 0));
            b = int'($urandom_range(1024, 0)) - 512;
            n = fit_count(p, b, int'($urandom_range(256, 0)));
            do_run(p, b, n, 1'b0);
        end

        // starts before the line, past its end, and fully outside
        do_run(-(int'($urandom_range(40, 1)) * 256) - 37, 256, 100, 1'b0);
        do_run(200 * 256 + 91, 384, 120, 1'b0);
        do_run(-5 * 256, -200, 64, 1'b0);
        do_run(300 * 256 + 13, -300, 256, 1'b0);

        // zero steps leaves the sum cleared
        do_run(17 * 256, 256, 0, 1'b0);
        apb_read(`BP_REG_SUM, rd, err);
        check_value("sum after zero-step run", longint'($signed(rd)), 0);

        // step write during a run is dropped, bad address errors
        do_run(10 * 256 + 128, 179, 200, 1'b1);
        apb_read(12'h418, rd, err);
        check_value("pslverr at 0x418", longint'(err), 1);
        apb_read(`BP_REG_SUM, rd, err);
        check_value("pslverr at ray sum", longint'(err), 0);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
